/* include/mips_consts.svh */
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`define RESET_PC 32'h0000_0000
`define NUM_REGS 32

// Primary opcodes.
`define OP_SPECIAL 6'h00
`define OP_BEQ     6'h04
`define OP_BNE     6'h05
`define OP_ADDIU   6'h09
`define OP_ORI     6'h0d
`define OP_LUI     6'h0f
`define OP_LW      6'h23
`define OP_SW      6'h2b

// Funct codes under SPECIAL.
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_SLT  6'h2a

`define ALU_OP_ADD 3'd0 // Zero so that a cleared payload is harmless.
`define ALU_OP_SUB 3'd1
`define ALU_OP_AND 3'd2
`define ALU_OP_OR  3'd3
`define ALU_OP_SLT 3'd4
`define ALU_OP_LUI 3'd5

`endif

/* design/mips_pkg.sv */
`include "mips_consts.svh"

package mips_pkg;

    typedef enum logic [2:0] {
        ALU_ADD = `ALU_OP_ADD,
        ALU_SUB = `ALU_OP_SUB,
        ALU_AND = `ALU_OP_AND,
        ALU_OR  = `ALU_OP_OR,
        ALU_SLT = `ALU_OP_SLT,
        ALU_LUI = `ALU_OP_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0, // All-zero payload means no access.
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    // ID/EX. Store data travels in rt_val.
    typedef struct packed {
        alu_op_e     alu_op;
        mem_op_e     mem_op;
        logic        use_imm;
        logic [31:0] imm;
        logic [31:0] rs_val;
        logic [31:0] rt_val;
        logic [4:0]  dest;
        logic        we;
    } ex_payload_t;

    // EX/MM. Result doubles as the data address.
    typedef struct packed {
        mem_op_e     mem_op;
        logic [31:0] result;
        logic [31:0] store_data;
        logic [4:0]  dest;
        logic        we;
    } mm_payload_t;

    typedef struct packed {
        logic [31:0] data;
        logic [4:0]  dest;
        logic        we;
    } wb_payload_t;

endpackage

/* design/stage_ctrl_if.sv */
`timescale 1ns/100ps

// Stage enables, with the clock and reset carried for checks on the bundle.
interface stage_ctrl_if (
    input logic clk,
    input logic rst_n
);
    logic en_pc;
    logic en_ifid;
    logic en_idex;
    logic en_exmm;
    logic en_mmwb;

    modport ctrl (
        input  clk, rst_n,
        output en_pc, en_ifid, en_idex, en_exmm, en_mmwb
    );

    modport stage (
        input en_pc, en_ifid, en_idex, en_exmm, en_mmwb
    );
endinterface

/* design/hazard_ctrl.sv */
`timescale 1ns/100ps

module hazard_ctrl (
    input  logic       ex_is_load_i,
    input  logic [4:0] ex_dest_i,
    input  logic [4:0] id_rs_i,
    input  logic [4:0] id_rt_i,
    stage_ctrl_if.ctrl ctrl
);
    logic load_use;

    // Load result is not ready until the memory stage.
    assign load_use = ex_is_load_i && (ex_dest_i != 5'd0) &&
                      ((ex_dest_i == id_rs_i) || (ex_dest_i == id_rt_i));

    // Freeze fetch and decode; a bubble goes into execute.
    assign ctrl.en_pc   = !load_use;
    assign ctrl.en_ifid = !load_use;
    assign ctrl.en_idex = !load_use;
    assign ctrl.en_exmm = 1'b1;
    assign ctrl.en_mmwb = 1'b1;

    // Only all-high or the stall pattern.
    assert property (@(posedge ctrl.clk) disable iff (!ctrl.rst_n)
        {ctrl.en_pc, ctrl.en_ifid, ctrl.en_idex, ctrl.en_exmm, ctrl.en_mmwb}
            inside {5'b11111, 5'b00011})
        else $error("hazard_ctrl: illegal enable pattern");

    // The bubble removes the load from execute, so a stall never repeats.
    assert property (@(posedge ctrl.clk) disable iff (!ctrl.rst_n)
        !ctrl.en_idex |=> ctrl.en_idex)
        else $error("hazard_ctrl: stall longer than one cycle");

endmodule

/* design/pipe_reg.sv */
`timescale 1ns/100ps

module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     en_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // A cleared payload has we low and no memory access.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_o <= '0;
        end else if (en_i) begin
            q_o <= d_i;
        end else if (flush_i) begin
            q_o <= '0; // Next stage moves on while this one is frozen.
        end
    end

endmodule

/* design/reg_file.sv */
`timescale 1ns/100ps
`include "mips_consts.svh"

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        we_i,
    input  logic [4:0]  waddr_i,
    input  logic [31:0] wdata_i,
    input  logic [4:0]  raddr1_i,
    input  logic [4:0]  raddr2_i,
    output logic [31:0] rdata1_o,
    output logic [31:0] rdata2_o
);
    logic [31:0] regs [`NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != 5'd0)) begin
            regs[waddr_i] <= wdata_i; // r0 stays zero.
        end
    end

    // Same-cycle writes are covered by the writeback bypass.
    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];

endmodule

/* design/decode_unit.sv */
`timescale 1ns/100ps
`include "mips_consts.svh"

module decode_unit (
    input  logic [31:0]           inst_i,
    input  logic [31:0]           pc_i,
    input  logic [31:0]           rs_val_i,
    input  logic [31:0]           rt_val_i,
    output logic [4:0]            rs_o,
    output logic [4:0]            rt_o,
    output mips_pkg::ex_payload_t payload_o,
    output logic                  branch_taken_o,
    output logic [31:0]           branch_target_o
);
    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [4:0]  rd;
    logic [31:0] imm_sext;
    logic [31:0] imm_zext;
    logic        reads_rs;
    logic        reads_rt;
    logic        is_beq;
    logic        is_bne;

    assign opcode   = inst_i[31:26];
    assign funct    = inst_i[5:0];
    assign rd       = inst_i[15:11];
    assign imm_sext = {{16{inst_i[15]}}, inst_i[15:0]};
    assign imm_zext = {16'b0, inst_i[15:0]};

    // Unused source fields read as r0 so they never cause a stall.
    assign reads_rs = (opcode != `OP_LUI);
    assign reads_rt = (opcode == `OP_SPECIAL) || (opcode == `OP_SW) || is_beq || is_bne;
    assign rs_o     = reads_rs ? inst_i[25:21] : 5'd0;
    assign rt_o     = reads_rt ? inst_i[20:16] : 5'd0;

    assign is_beq = (opcode == `OP_BEQ);
    assign is_bne = (opcode == `OP_BNE);
    assign branch_taken_o  = (is_beq && (rs_val_i == rt_val_i)) ||
                             (is_bne && (rs_val_i != rt_val_i));
    assign branch_target_o = pc_i + 32'd4 + {imm_sext[29:0], 2'b00}; // Relative to delay slot.

    always_comb begin
        payload_o        = '0;
        payload_o.rs_val = rs_val_i;
        payload_o.rt_val = rt_val_i;
        case (opcode)
            `OP_SPECIAL: begin
                payload_o.dest = rd;
                payload_o.we   = 1'b1;
                case (funct)
                    `FN_ADDU: payload_o.alu_op = mips_pkg::ALU_ADD;
                    `FN_SUBU: payload_o.alu_op = mips_pkg::ALU_SUB;
                    `FN_AND:  payload_o.alu_op = mips_pkg::ALU_AND;
                    `FN_OR:   payload_o.alu_op = mips_pkg::ALU_OR;
                    `FN_SLT:  payload_o.alu_op = mips_pkg::ALU_SLT;
                    default:  payload_o.we     = 1'b0; // Includes SLL r0 (NOP).
                endcase
            end
            `OP_ADDIU, `OP_ORI, `OP_LUI, `OP_LW: begin
                payload_o.use_imm = 1'b1;
                payload_o.imm     = (opcode == `OP_ADDIU || opcode == `OP_LW) ? imm_sext
                                                                               : imm_zext;
                payload_o.dest    = inst_i[20:16];
                payload_o.we      = 1'b1;
                if (opcode == `OP_ORI) payload_o.alu_op = mips_pkg::ALU_OR;
                if (opcode == `OP_LUI) payload_o.alu_op = mips_pkg::ALU_LUI;
                if (opcode == `OP_LW)  payload_o.mem_op = mips_pkg::MEM_LOAD;
            end
            `OP_SW: begin
                payload_o.use_imm = 1'b1;
                payload_o.imm     = imm_sext;
                payload_o.mem_op  = mips_pkg::MEM_STORE;
            end
            default: ; // Branches and unknown encodings leave a bubble.
        endcase
    end

    // Holds only while the fetch PC stays word aligned.
    always_comb begin
        if (branch_taken_o) begin
            assert (branch_target_o[1:0] == 2'b00)
                else $error("decode_unit: misaligned branch target");
        end
    end

endmodule

/* design/operand_bypass.sv */
`timescale 1ns/100ps

module operand_bypass (
    input  logic [4:0]  reg_i,
    input  logic [31:0] regfile_val_i,
    input  logic [4:0]  ex_dest_i,
    input  logic        ex_we_i,
    input  logic [31:0] ex_result_i,
    input  logic        ex_is_load_i,
    input  logic [4:0]  mm_dest_i,
    input  logic        mm_we_i,
    input  logic [31:0] mm_data_i,
    input  logic [4:0]  wb_dest_i,
    input  logic        wb_we_i,
    input  logic [31:0] wb_data_i,
    output logic [31:0] val_o
);

    // Youngest producer wins.
    always_comb begin
        if (reg_i == 5'd0) begin
            val_o = 32'd0;
        end else if (ex_we_i && !ex_is_load_i && ex_dest_i == reg_i) begin
            val_o = ex_result_i; // A load here stalls decode instead.
        end else if (mm_we_i && mm_dest_i == reg_i) begin
            val_o = mm_data_i;
        end else if (wb_we_i && wb_dest_i == reg_i) begin
            val_o = wb_data_i;
        end else begin
            val_o = regfile_val_i;
        end
    end

endmodule

/* design/alu_exec.sv */
`timescale 1ns/100ps

module alu_exec (
    input  mips_pkg::ex_payload_t payload_i,
    output mips_pkg::mm_payload_t payload_o,
    output logic                  is_load_o
);
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] result;

    assign op_a = payload_i.rs_val;
    assign op_b = payload_i.use_imm ? payload_i.imm : payload_i.rt_val;

    always_comb begin
        case (payload_i.alu_op)
            mips_pkg::ALU_ADD: result = op_a + op_b; // Also the load/store address.
            mips_pkg::ALU_SUB: result = op_a - op_b;
            mips_pkg::ALU_AND: result = op_a & op_b;
            mips_pkg::ALU_OR:  result = op_a | op_b;
            mips_pkg::ALU_SLT: result = {31'd0, $signed(op_a) < $signed(op_b)};
            mips_pkg::ALU_LUI: result = {op_b[15:0], 16'd0};
            default:           result = 32'd0;
        endcase
    end

    always_comb begin
        payload_o.mem_op     = payload_i.mem_op;
        payload_o.result     = result;
        payload_o.store_data = payload_i.rt_val;
        payload_o.dest       = payload_i.dest;
        payload_o.we         = payload_i.we;
    end

    assign is_load_o = (payload_i.mem_op == mips_pkg::MEM_LOAD);

endmodule

/* design/mem_stage.sv */
`timescale 1ns/100ps

module mem_stage (
    input  mips_pkg::mm_payload_t payload_i,
    input  logic [31:0]           dmem_rdata_i,
    output logic [31:0]           dmem_addr_o,
    output logic                  dmem_rd_o,
    output logic                  dmem_wr_o,
    output logic [31:0]           dmem_wdata_o,
    output mips_pkg::wb_payload_t payload_o
);

    assign dmem_addr_o  = payload_i.result;
    assign dmem_rd_o    = (payload_i.mem_op == mips_pkg::MEM_LOAD);
    assign dmem_wr_o    = (payload_i.mem_op == mips_pkg::MEM_STORE);
    assign dmem_wdata_o = payload_i.store_data;

    always_comb begin
        payload_o.data = dmem_rd_o ? dmem_rdata_i : payload_i.result;
        payload_o.dest = payload_i.dest;
        payload_o.we   = payload_i.we;
    end

    // Word accesses only.
    always_comb begin
        assert (!(dmem_rd_o && dmem_wr_o)) else $error("mem_stage: read and write together");
        if (dmem_rd_o || dmem_wr_o) begin
            assert (dmem_addr_o[1:0] == 2'b00) else $error("mem_stage: misaligned access");
        end
    end

endmodule

/* design/naive_mips.sv */
`timescale 1ns/100ps
`include "mips_consts.svh"

module naive_mips (
    input  logic        clk,
    input  logic        rst_n,
    output logic [31:0] imem_addr_o,
    input  logic [31:0] imem_rdata_i,
    output logic [31:0] dmem_addr_o,
    output logic        dmem_rd_o,
    output logic        dmem_wr_o,
    output logic [31:0] dmem_wdata_o,
    input  logic [31:0] dmem_rdata_i
);
    logic [31:0] pc;
    logic [31:0] id_inst;
    logic [31:0] id_pc;
    logic [4:0]  id_rs;
    logic [4:0]  id_rt;
    logic [31:0] rf_rs_val;
    logic [31:0] rf_rt_val;
    logic [31:0] id_rs_val;
    logic [31:0] id_rt_val;
    logic        branch_taken;
    logic [31:0] branch_target;
    logic        ex_is_load;

    mips_pkg::ex_payload_t id_payload;
    mips_pkg::ex_payload_t ex_payload;
    mips_pkg::mm_payload_t ex_out;
    mips_pkg::mm_payload_t mm_payload;
    mips_pkg::wb_payload_t mm_out;
    mips_pkg::wb_payload_t wb_payload;

    stage_ctrl_if ctrl_if (.clk(clk), .rst_n(rst_n));

    hazard_ctrl u_hazard (
        .ex_is_load_i (ex_is_load),
        .ex_dest_i    (ex_payload.dest),
        .id_rs_i      (id_rs),
        .id_rt_i      (id_rt),
        .ctrl         (ctrl_if.ctrl)
    );

    // Fetch. The slot after a branch is already being fetched when it resolves.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else if (ctrl_if.en_pc) begin
            pc <= branch_taken ? branch_target : pc + 32'd4;
        end
    end

    assign imem_addr_o = pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_inst <= 32'd0;
            id_pc   <= `RESET_PC;
        end else if (ctrl_if.en_ifid) begin
            id_inst <= imem_rdata_i;
            id_pc   <= pc;
        end else if (ctrl_if.en_idex) begin
            id_inst <= 32'd0; // NOP.
        end
    end

    reg_file u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .we_i     (wb_payload.we),
        .waddr_i  (wb_payload.dest),
        .wdata_i  (wb_payload.data),
        .raddr1_i (id_rs),
        .raddr2_i (id_rt),
        .rdata1_o (rf_rs_val),
        .rdata2_o (rf_rt_val)
    );

    operand_bypass u_bypass_rs (
        .reg_i (id_rs), .regfile_val_i (rf_rs_val),
        .ex_dest_i (ex_out.dest), .ex_we_i (ex_out.we),
        .ex_result_i (ex_out.result), .ex_is_load_i (ex_is_load),
        .mm_dest_i (mm_out.dest), .mm_we_i (mm_out.we), .mm_data_i (mm_out.data),
        .wb_dest_i (wb_payload.dest), .wb_we_i (wb_payload.we), .wb_data_i (wb_payload.data),
        .val_o (id_rs_val)
    );

    operand_bypass u_bypass_rt (
        .reg_i (id_rt), .regfile_val_i (rf_rt_val),
        .ex_dest_i (ex_out.dest), .ex_we_i (ex_out.we),
        .ex_result_i (ex_out.result), .ex_is_load_i (ex_is_load),
        .mm_dest_i (mm_out.dest), .mm_we_i (mm_out.we), .mm_data_i (mm_out.data),
        .wb_dest_i (wb_payload.dest), .wb_we_i (wb_payload.we), .wb_data_i (wb_payload.data),
        .val_o (id_rt_val)
    );

    decode_unit u_decode (
        .inst_i          (id_inst),
        .pc_i            (id_pc),
        .rs_val_i        (id_rs_val),
        .rt_val_i        (id_rt_val),
        .rs_o            (id_rs),
        .rt_o            (id_rt),
        .payload_o       (id_payload),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target)
    );

    pipe_reg #(.payload_t(mips_pkg::ex_payload_t)) u_idex (
        .clk (clk), .rst_n (rst_n),
        .en_i (ctrl_if.en_idex), .flush_i (ctrl_if.en_exmm),
        .d_i (id_payload), .q_o (ex_payload)
    );

    alu_exec u_alu (
        .payload_i (ex_payload),
        .payload_o (ex_out),
        .is_load_o (ex_is_load)
    );

    pipe_reg #(.payload_t(mips_pkg::mm_payload_t)) u_exmm (
        .clk (clk), .rst_n (rst_n),
        .en_i (ctrl_if.en_exmm), .flush_i (ctrl_if.en_mmwb),
        .d_i (ex_out), .q_o (mm_payload)
    );

    mem_stage u_mem (
        .payload_i    (mm_payload),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_rd_o    (dmem_rd_o),
        .dmem_wr_o    (dmem_wr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .payload_o    (mm_out)
    );

    // Last stage, nothing downstream to wait for.
    pipe_reg #(.payload_t(mips_pkg::wb_payload_t)) u_mmwb (
        .clk (clk), .rst_n (rst_n),
        .en_i (ctrl_if.en_mmwb), .flush_i (1'b1),
        .d_i (mm_out), .q_o (wb_payload)
    );

endmodule

/* tb/tb_naive_mips.sv */
`timescale 1ns/100ps
`include "mips_consts.svh"

module tb_naive_mips;
    localparam int NUM_TESTS       = 5;
    localparam int MAX_TEST_CYCLES = 200;
    localparam int TIMEOUT_CYCLES  = NUM_TESTS * MAX_TEST_CYCLES + 200;
    localparam logic [31:0] END_ADDR = 32'h0000_03fc;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_addr;
    logic        dmem_rd;
    logic        dmem_wr;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] st_addr [$];
    logic [31:0] st_data [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] ld_addr [$];
    logic [31:0] exp_ld_addr [$];
    logic        test_done;
    logic [31:0] lcg_state;
    int          prog_len;
    int          cycles;
    int          checks;
    int          errors;

    naive_mips u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_rdata_i (imem_rdata),
        .dmem_addr_o  (dmem_addr),
        .dmem_rd_o    (dmem_rd),
        .dmem_wr_o    (dmem_wr),
        .dmem_wdata_o (dmem_wdata),
        .dmem_rdata_i (dmem_rdata)
    );

    always #10 clk = ~clk;

    // Both memories answer in the same cycle.
    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (rst_n && dmem_rd) begin
            ld_addr.push_back(dmem_addr);
        end
        if (rst_n && dmem_wr) begin
            if (dmem_addr == END_ADDR) begin
                test_done = 1'b1;
            end else begin
                dmem[dmem_addr[9:2]] = dmem_wdata;
                st_addr.push_back(dmem_addr);
                st_data.push_back(dmem_wdata);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Simulation failed");
            $display("Timeout: no end-of-test store after %0d cycles", cycles);
            $finish;
        end
    end

    function automatic logic [31:0] r_type(input logic [5:0] fn, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt);
        return {`OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rt,
                                           input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] signed_less(input logic [31:0] a, input logic [31:0] b);
        return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endfunction

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic emit(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic expect_load(input logic [31:0] addr);
        exp_ld_addr.push_back(addr);
    endtask

    // Hold the core in reset while both memories are rewritten.
    task automatic begin_test();
        @(posedge clk);
        #1 rst_n = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'd0; // NOP.
            dmem[i] = 32'hd000_0000 | i;
        end
        prog_len  = 0;
        test_done = 1'b0;
        st_addr.delete();
        st_data.delete();
        exp_addr.delete();
        exp_data.delete();
        ld_addr.delete();
        exp_ld_addr.delete();
    endtask

    task automatic run_program();
        emit(i_type(`OP_SW, 5'd0, 5'd0, END_ADDR[15:0]));
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        while (!test_done) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic compare_stores(input string name);
        int n;
        n = (st_addr.size() < exp_addr.size()) ? st_addr.size() : exp_addr.size();
        check_val({name, " store count"}, 32'(st_addr.size()), 32'(exp_addr.size()));
        for (int i = 0; i < n; i++) begin
            check_val($sformatf("%s store %0d address", name, i), st_addr[i], exp_addr[i]);
            check_val($sformatf("%s store %0d data", name, i), st_data[i], exp_data[i]);
        end
    endtask

    task automatic compare_loads(input string name);
        int n;
        n = (ld_addr.size() < exp_ld_addr.size()) ? ld_addr.size() : exp_ld_addr.size();
        check_val({name, " load count"}, 32'(ld_addr.size()), 32'(exp_ld_addr.size()));
        for (int i = 0; i < n; i++) begin
            check_val($sformatf("%s load %0d address", name, i), ld_addr[i], exp_ld_addr[i]);
        end
    endtask

    task automatic alu_chain_test();
        logic [31:0] e [10];
        begin_test();
        emit(i_type(`OP_ADDIU, 5'd1, 5'd0, 16'h1234));
        emit(r_type(`FN_ADDU, 5'd2, 5'd1, 5'd1));
        emit(r_type(`FN_SUBU, 5'd3, 5'd2, 5'd1));
        emit(r_type(`FN_AND, 5'd4, 5'd3, 5'd2));
        emit(r_type(`FN_OR, 5'd5, 5'd4, 5'd1));
        emit(r_type(`FN_SLT, 5'd6, 5'd5, 5'd2));
        emit(r_type(`FN_SUBU, 5'd7, 5'd0, 5'd2));
        emit(r_type(`FN_SLT, 5'd8, 5'd7, 5'd6)); // Negative against small positive.
        emit(i_type(`OP_ADDIU, 5'd9, 5'd8, 16'hfffb));
        for (int r = 1; r <= 9; r++) begin
            emit(i_type(`OP_SW, 5'(r), 5'd0, 16'(16'h0100 + 4 * (r - 1))));
        end
        e[1] = 32'h0000_1234;
        e[2] = e[1] + e[1];
        e[3] = e[2] - e[1];
        e[4] = e[3] & e[2];
        e[5] = e[4] | e[1];
        e[6] = signed_less(e[5], e[2]);
        e[7] = 32'd0 - e[2];
        e[8] = signed_less(e[7], e[6]);
        e[9] = e[8] + 32'hffff_fffb;
        for (int r = 1; r <= 9; r++) begin
            expect_store(32'h0000_0100 + 4 * (r - 1), e[r]);
        end
        run_program();
        compare_stores("alu chain");
        compare_loads("alu chain");
    endtask

    task automatic load_use_test();
        logic [31:0] word_a;
        logic [31:0] word_b;
        word_a = 32'h0001_2345;
        word_b = 32'h0000_0f00;
        begin_test();
        dmem[32] = word_a;
        dmem[33] = word_b;
        emit(i_type(`OP_ADDIU, 5'd2, 5'd0, 16'h0321));
        emit(i_type(`OP_LW, 5'd1, 5'd0, 16'h0080));
        emit(r_type(`FN_ADDU, 5'd3, 5'd1, 5'd2)); // Stalls on rs.
        emit(i_type(`OP_SW, 5'd3, 5'd0, 16'h0104));
        emit(i_type(`OP_LW, 5'd5, 5'd0, 16'h0084));
        emit(r_type(`FN_SUBU, 5'd6, 5'd2, 5'd5)); // Stalls on rt.
        emit(i_type(`OP_SW, 5'd6, 5'd0, 16'h0108));
        emit(i_type(`OP_LW, 5'd7, 5'd0, 16'h0080));
        emit(i_type(`OP_SW, 5'd7, 5'd0, 16'h010c));
        expect_store(32'h0000_0104, word_a + 32'h0000_0321);
        expect_store(32'h0000_0108, 32'h0000_0321 - word_b);
        expect_store(32'h0000_010c, word_a);
        expect_load(32'h0000_0080);
        expect_load(32'h0000_0084);
        expect_load(32'h0000_0080);
        run_program();
        compare_stores("load use");
        compare_loads("load use");
    endtask

    task automatic branch_test();
        begin_test();
        emit(i_type(`OP_ADDIU, 5'd1, 5'd0, 16'h0005));
        emit(i_type(`OP_ADDIU, 5'd2, 5'd0, 16'h0005));
        emit(i_type(`OP_ADDIU, 5'd3, 5'd0, 16'h0009));
        emit(i_type(`OP_BEQ, 5'd2, 5'd1, 16'd3));    // Taken, lands on word 7.
        emit(i_type(`OP_SW, 5'd3, 5'd0, 16'h0200));  // Delay slot.
        emit(i_type(`OP_SW, 5'd3, 5'd0, 16'h0204));
        emit(i_type(`OP_SW, 5'd3, 5'd0, 16'h0208));
        emit(i_type(`OP_BNE, 5'd2, 5'd1, 16'd5));    // Not taken.
        emit(i_type(`OP_SW, 5'd3, 5'd0, 16'h020c));
        emit(i_type(`OP_SW, 5'd3, 5'd0, 16'h0210));
        emit(i_type(`OP_BEQ, 5'd3, 5'd1, 16'd2));    // Not taken.
        emit(i_type(`OP_SW, 5'd3, 5'd0, 16'h0214));
        emit(i_type(`OP_SW, 5'd3, 5'd0, 16'h0218));
        expect_store(32'h0000_0200, 32'd9);
        expect_store(32'h0000_020c, 32'd9);
        expect_store(32'h0000_0210, 32'd9);
        expect_store(32'h0000_0214, 32'd9);
        expect_store(32'h0000_0218, 32'd9);
        run_program();
        compare_stores("branch");
        compare_loads("branch");
    endtask

    task automatic const_zero_test();
        logic [31:0] value;
        value = {16'hdead, 16'h0000} | {16'h0000, 16'hbeef};
        begin_test();
        emit(i_type(`OP_LUI, 5'd1, 5'd0, 16'hdead));
        emit(i_type(`OP_ORI, 5'd1, 5'd1, 16'hbeef));
        emit(i_type(`OP_ADDIU, 5'd0, 5'd0, 16'h0055));
        emit(r_type(`FN_ADDU, 5'd0, 5'd1, 5'd1));
        emit(r_type(`FN_ADDU, 5'd3, 5'd0, 5'd1)); // r0 must not forward.
        emit(i_type(`OP_ORI, 5'd2, 5'd0, 16'h8001));
        emit(i_type(`OP_SW, 5'd1, 5'd0, 16'h0300));
        emit(i_type(`OP_SW, 5'd0, 5'd0, 16'h0304));
        emit(i_type(`OP_SW, 5'd2, 5'd0, 16'h0308));
        emit(i_type(`OP_SW, 5'd3, 5'd0, 16'h030c));
        expect_store(32'h0000_0300, value);
        expect_store(32'h0000_0304, 32'd0);
        expect_store(32'h0000_0308, 32'h0000_8001); // ORI zero-extends.
        expect_store(32'h0000_030c, value);
        run_program();
        compare_stores("constants");
        compare_loads("constants");
    endtask

    task automatic random_arith_test();
        logic [31:0] a;
        logic [31:0] b;
        logic [15:0] base;
        begin_test();
        for (int k = 0; k < 8; k++) begin
            dmem[96 + k] = next_rand(); // Words from 0x180.
        end
        for (int k = 0; k < 4; k++) begin
            base = 16'(16'h0280 + 12 * k);
            emit(i_type(`OP_LW, 5'd1, 5'd0, 16'(16'h0180 + 8 * k)));
            emit(i_type(`OP_LW, 5'd2, 5'd0, 16'(16'h0184 + 8 * k)));
            emit(r_type(`FN_ADDU, 5'd3, 5'd1, 5'd2));
            emit(r_type(`FN_SUBU, 5'd4, 5'd1, 5'd2));
            emit(r_type(`FN_SLT, 5'd5, 5'd1, 5'd2));
            emit(i_type(`OP_SW, 5'd3, 5'd0, base));
            emit(i_type(`OP_SW, 5'd4, 5'd0, base + 16'd4));
            emit(i_type(`OP_SW, 5'd5, 5'd0, base + 16'd8));
            a = dmem[96 + 2 * k];
            b = dmem[97 + 2 * k];
            expect_load(32'h0000_0180 + 8 * k);
            expect_load(32'h0000_0184 + 8 * k);
            expect_store({16'd0, base}, a + b);
            expect_store({16'd0, base + 16'd4}, a - b);
            expect_store({16'd0, base + 16'd8}, signed_less(a, b));
        end
        run_program();
        compare_stores("random");
        compare_loads("random");
        for (int i = 1; i < st_addr.size(); i++) begin
            check_val($sformatf("random store %0d in order", i),
                      {31'd0, st_addr[i] > st_addr[i - 1]}, 32'd1);
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        test_done  = 1'b0;
        lcg_state  = 32'd21;
        prog_len   = 0;
        cycles     = 0;
        checks     = 0;
        errors     = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'd0;
            dmem[i] = 32'hd000_0000 | i;
        end

        alu_chain_test();
        load_use_test();
        branch_test();
        const_zero_test();
        random_arith_test();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
design/mips_pkg.sv
design/stage_ctrl_if.sv
design/hazard_ctrl.sv
design/pipe_reg.sv
design/reg_file.sv
design/decode_unit.sv
design/operand_bypass.sv
design/alu_exec.sv
design/mem_stage.sv
design/naive_mips.sv
tb/tb_naive_mips.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_naive_mips
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
